// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_priv_unit
DUT_TOP    ?= priv_unit
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing --assert --timescale $(TIMESCALE)
FAIL_MSG   := *** FAILED ***
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation incomplete, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== machine_csr_pkg.sv ====
// Machine CSR addresses, privilege levels, mtvec modes and misa fields
package machine_csr_pkg;

  // Supported machine CSRs; bits 9:8 give the lowest privilege allowed
  typedef enum logic [11:0] {
    // Machine information, read only
    MVENDORID_ADDR     = 12'hF11,
    MARCHID_ADDR       = 12'hF12,
    MIMPID_ADDR        = 12'hF13,
    MHARTID_ADDR       = 12'hF14,
    MCONFIGPTR_ADDR    = 12'hF15,
    // Trap setup
    MSTATUS_ADDR       = 12'h300,
    MISA_ADDR          = 12'h301,
    MIE_ADDR           = 12'h304,
    MTVEC_ADDR         = 12'h305,
    MCOUNTEREN_ADDR    = 12'h306,
    MSTATUSH_ADDR      = 12'h310,
    MCOUNTINHIBIT_ADDR = 12'h320,
    // Trap handling
    MSCRATCH_ADDR      = 12'h340,
    MEPC_ADDR          = 12'h341,
    MCAUSE_ADDR        = 12'h342,
    MTVAL_ADDR         = 12'h343,
    MIP_ADDR           = 12'h344,
    // Counters
    MCYCLE_ADDR        = 12'hB00,
    MINSTRET_ADDR      = 12'hB02,
    MCYCLEH_ADDR       = 12'hB80,
    MINSTRETH_ADDR     = 12'hB82
  } csr_addr_t;

  // Only U and M exist, no supervisor level
  typedef enum logic [1:0] {
    U_MODE = 2'b00,
    M_MODE = 2'b11
  } priv_level_t;

  typedef enum logic [1:0] {
    DIRECT   = 2'b00,
    VECTORED = 2'b01
  } vector_mode_t;

  // misa fields
  localparam logic [31:0] BASE_RV32  = 32'h4000_0000;  // MXL = 1, 32-bit
  localparam logic [31:0] MISA_EXT_I = 32'h0000_0100;  // Bit 8
  localparam logic [31:0] MISA_EXT_M = 32'h0000_1000;  // Bit 12
  localparam logic [31:0] MISA_EXT_U = 32'h0010_0000;  // Bit 20

endpackage

// ==== priv_csr_file.sv ====
// Machine CSR file with CSR operations, access checks, counters and trap updates
`include "priv_params.svh"

module priv_csr_file import machine_csr_pkg::*, trap_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         csr_write,
  input  logic         csr_set,
  input  logic         csr_clear,
  input  csr_addr_t    csr_addr,
  input  logic [31:0]  csr_wdata,
  input  priv_level_t  curr_priv,
  input  logic         inst_ret,
  input  logic         ext_irq,
  input  logic         timer_irq,
  input  logic         trap_enter,
  input  logic         trap_is_int,
  input  logic [3:0]   trap_cause,
  input  logic [31:0]  trap_epc,
  input  logic [31:0]  trap_tval,
  input  logic         mret_commit,
  output logic [31:0]  csr_rdata,
  output logic         invalid_csr,
  output logic         mstatus_mie,
  output priv_level_t  mstatus_mpp,
  output logic [11:0]  mie_bits,
  output logic [11:0]  mip_bits,
  output logic [29:0]  mtvec_base,
  output vector_mode_t mtvec_mode,
  output logic [31:0]  mepc
);

  localparam logic [11:0] IRQ_MASK = (12'd1 << MSIP_BIT) | (12'd1 << MTIP_BIT) |
                                     (12'd1 << MEIP_BIT);
  localparam int CY_BIT = 0;  // mcountinhibit.CY
  localparam int IR_BIT = 2;  // mcountinhibit.IR

  logic                   mstatus_mpie;
  logic                   msip, mtip, meip;
  logic [31:0]            mscratch, mcause, mtval;
  logic [31:0]            mcounteren, mcountinhibit;
  logic [`PRIV_CNT_W-1:0] mcycle, minstret;

  logic [11:0]  addr_raw;
  logic         addr_known;
  logic         csr_op, csr_we;
  logic [31:0]  old_val, nxt_val;
  logic [31:0]  misa_val, mstatus_val;
  priv_level_t  nxt_mpp;
  vector_mode_t nxt_mode;

  assign addr_raw = csr_addr;
  assign misa_val = BASE_RV32 | MISA_EXT_I | ({32{`PRIV_EXT_M}} & MISA_EXT_M) |
                    ({32{`PRIV_EXT_U}} & MISA_EXT_U);
  // FS, VS, XS and SD stay zero
  assign mstatus_val = {19'b0, mstatus_mpp, 3'b0, mstatus_mpie, 3'b0, mstatus_mie, 3'b0};

  always_comb begin
    mip_bits           = '0;
    mip_bits[MSIP_BIT] = msip;
    mip_bits[MTIP_BIT] = mtip;
    mip_bits[MEIP_BIT] = meip;
  end

  // Read mux, also tells which addresses exist
  always_comb begin
    old_val    = '0;
    addr_known = 1'b1;
    case (csr_addr)
      MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MCONFIGPTR_ADDR, MSTATUSH_ADDR: old_val = '0;
      MHARTID_ADDR:       old_val = `PRIV_HARTID;
      MSTATUS_ADDR:       old_val = mstatus_val;
      MISA_ADDR:          old_val = misa_val;
      MIE_ADDR:           old_val = {20'b0, mie_bits};
      MTVEC_ADDR:         old_val = {mtvec_base, mtvec_mode};
      MCOUNTEREN_ADDR:    old_val = mcounteren;
      MCOUNTINHIBIT_ADDR: old_val = mcountinhibit;
      MSCRATCH_ADDR:      old_val = mscratch;
      MEPC_ADDR:          old_val = mepc;
      MCAUSE_ADDR:        old_val = mcause;
      MTVAL_ADDR:         old_val = mtval;
      MIP_ADDR:           old_val = {20'b0, mip_bits};
      MCYCLE_ADDR:        old_val = mcycle[31:0];
      MINSTRET_ADDR:      old_val = minstret[31:0];
      MCYCLEH_ADDR:       old_val = mcycle[`PRIV_CNT_W-1:32];
      MINSTRETH_ADDR:     old_val = minstret[`PRIV_CNT_W-1:32];
      default:            addr_known = 1'b0;
    endcase
  end

  assign csr_rdata   = old_val;
  assign invalid_csr = !addr_known || (addr_raw[9:8] > curr_priv);  // Unknown or too little privilege

  assign csr_op = csr_write | csr_set | csr_clear;
  assign csr_we = csr_op & ~invalid_csr;

  // Write, set or clear against the current value
  always_comb begin
    if (csr_set) begin
      nxt_val = old_val | csr_wdata;
    end else if (csr_clear) begin
      nxt_val = old_val & ~csr_wdata;
    end else begin
      nxt_val = csr_wdata;
    end
    // WARL fixes: 2 and the absent S level fall back to U, modes above 1 to DIRECT
    nxt_mpp  = (nxt_val[12:11] == M_MODE) ? M_MODE : U_MODE;
    nxt_mode = (nxt_val[1:0] == VECTORED) ? VECTORED : DIRECT;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_mie   <= 1'b0;
      mstatus_mpie  <= 1'b0;
      mstatus_mpp   <= M_MODE;
      mie_bits      <= '0;
      msip          <= 1'b0;
      mtip          <= 1'b0;
      meip          <= 1'b0;
      mtvec_base    <= '0;
      mtvec_mode    <= DIRECT;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= '1;
      mcountinhibit <= '1;  // Counters frozen until software enables them
    end else begin
      mtip <= timer_irq;  // Lines copied every cycle
      meip <= ext_irq;
      if (csr_we) begin
        case (csr_addr)
          MSTATUS_ADDR: begin
            mstatus_mie  <= nxt_val[3];
            mstatus_mpie <= nxt_val[7];
            mstatus_mpp  <= nxt_mpp;
          end
          MTVEC_ADDR: begin
            mtvec_base <= nxt_val[31:2];
            mtvec_mode <= nxt_mode;
          end
          MIE_ADDR:           mie_bits <= nxt_val[11:0] & IRQ_MASK;
          MIP_ADDR:           msip <= nxt_val[MSIP_BIT];  // Only msip is software writable
          MCOUNTEREN_ADDR:    mcounteren <= nxt_val;
          MCOUNTINHIBIT_ADDR: mcountinhibit <= nxt_val;
          MSCRATCH_ADDR:      mscratch <= nxt_val;
          MEPC_ADDR:          mepc <= nxt_val;
          MCAUSE_ADDR:        mcause <= nxt_val;
          MTVAL_ADDR:         mtval <= nxt_val;
          default: ;
        endcase
      end
      // Trap entry and mret win over a CSR write in the same cycle
      if (trap_enter) begin
        mepc         <= trap_epc;
        mcause       <= {trap_is_int, 27'b0, trap_cause};
        mtval        <= trap_tval;
        mstatus_mpie <= mstatus_mie;
        mstatus_mie  <= 1'b0;
        mstatus_mpp  <= curr_priv;
      end else if (mret_commit) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
        mstatus_mpp  <= U_MODE;
      end
    end
  end

  // Counters, a write to the low half wins over the increment
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      if (csr_we && csr_addr == MCYCLE_ADDR) begin
        mcycle <= {mcycle[`PRIV_CNT_W-1:32], nxt_val};
      end else if (!mcountinhibit[CY_BIT]) begin
        mcycle <= mcycle + `PRIV_CNT_W'(1);
      end
      if (csr_we && csr_addr == MINSTRET_ADDR) begin
        minstret <= {minstret[`PRIV_CNT_W-1:32], nxt_val};
      end else if (!mcountinhibit[IR_BIT]) begin
        minstret <= minstret + `PRIV_CNT_W'(inst_ret);
      end
    end
  end

  // Core issues one CSR operation at a time
  a_csr_op_onehot: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({csr_write, csr_set, csr_clear}));

  // Trap controller never enters and returns in one cycle
  a_trap_mret_excl: assert property (@(posedge CLK) disable iff (!nRST)
    !(trap_enter && mret_commit));

endmodule

// ==== priv_params.svh ====
// Hart id, supported extension flags and counter width for the privilege unit
`ifndef PRIV_PARAMS_SVH
`define PRIV_PARAMS_SVH

// Value returned by mhartid
`define PRIV_HARTID 32'd0

// Extensions reported in misa, one bit each
`define PRIV_EXT_M 1'b1
`define PRIV_EXT_U 1'b1

// Width of mcycle and minstret, read as two 32-bit halves
`define PRIV_CNT_W 64

`endif

// ==== priv_trap_control.sv ====
// Trap controller with interrupt arbitration, exception entry, mret and privilege level
module priv_trap_control import machine_csr_pkg::*, trap_pkg::*; (
  input  logic         CLK,
  input  logic         nRST,
  input  logic         exc_valid,
  input  exc_cause_t   exc_cause,
  input  logic [31:0]  exc_epc,
  input  logic [31:0]  exc_tval,
  input  logic         mret,
  input  logic         mstatus_mie,
  input  priv_level_t  mstatus_mpp,
  input  logic [11:0]  mie_bits,
  input  logic [11:0]  mip_bits,
  input  logic [29:0]  mtvec_base,
  input  vector_mode_t mtvec_mode,
  input  logic [31:0]  mepc,
  output logic         trap_enter,
  output logic         trap_is_int,
  output logic [3:0]   trap_cause,
  output logic [31:0]  trap_epc,
  output logic [31:0]  trap_tval,
  output logic         mret_commit,
  output logic         redirect,
  output logic [31:0]  redirect_pc,
  output priv_level_t  curr_priv
);

  logic [11:0] int_pending;
  logic        int_any;
  logic        int_enable;
  logic        int_take;
  int_cause_t  int_code;
  logic [31:0] trap_base;
  logic [31:0] vec_off;

  assign int_pending = mie_bits & mip_bits;
  assign int_any     = int_pending[MEIP_BIT] | int_pending[MSIP_BIT] | int_pending[MTIP_BIT];
  // Lower privilege always takes machine interrupts
  assign int_enable  = mstatus_mie | (curr_priv == U_MODE);
  assign int_take    = int_enable & int_any;

  // Fixed priority external, software, timer
  always_comb begin
    int_code = INT_M_TIMER;  // Timer when neither of the others is pending
    if (int_pending[MEIP_BIT]) begin
      int_code = INT_M_EXT;
    end else if (int_pending[MSIP_BIT]) begin
      int_code = INT_M_SOFT;
    end
  end

  // Exceptions beat interrupts, both beat mret
  always_comb begin
    trap_enter  = exc_valid | int_take;
    trap_is_int = !exc_valid && int_take;
    trap_epc    = exc_epc;  // Interrupted instruction for interrupts
    if (exc_valid) begin
      trap_cause = exc_cause;
      trap_tval  = exc_tval;
    end else begin
      trap_cause = int_code;
      trap_tval  = '0;
    end
  end

  assign mret_commit = mret && (curr_priv == M_MODE) && !trap_enter;  // Ignored in U mode
  assign redirect    = trap_enter | mret_commit;

  // Exceptions always go to the base address
  assign trap_base = {mtvec_base, 2'b00};
  assign vec_off   = (trap_is_int && mtvec_mode == VECTORED) ? {26'b0, trap_cause, 2'b00} : '0;

  always_comb begin
    if (trap_enter) begin
      redirect_pc = trap_base + vec_off;
    end else begin
      redirect_pc = mepc;
    end
  end

  // Privilege level register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      curr_priv <= M_MODE;
    end else if (trap_enter) begin
      curr_priv <= M_MODE;
    end else if (mret_commit) begin
      curr_priv <= mstatus_mpp;  // mpp read before the CSR file clears it
    end
  end

  // Handler runs in M mode with mie cleared and the old level saved in mpp
  a_trap_to_m: assert property (@(posedge CLK) disable iff (!nRST)
    trap_enter |=> (curr_priv == M_MODE) && !mstatus_mie &&
                   (mstatus_mpp == $past(curr_priv)));

endmodule

// ==== priv_unit.sv ====
// Privilege unit top joining the machine CSR file and the trap controller
module priv_unit import machine_csr_pkg::*, trap_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        csr_write,
  input  logic        csr_set,
  input  logic        csr_clear,
  input  csr_addr_t   csr_addr,
  input  logic [31:0] csr_wdata,
  input  logic        exc_valid,
  input  exc_cause_t  exc_cause,
  input  logic [31:0] exc_epc,
  input  logic [31:0] exc_tval,
  input  logic        mret,
  input  logic        inst_ret,
  input  logic        ext_irq,
  input  logic        timer_irq,
  output logic [31:0] csr_rdata,
  output logic        invalid_csr,
  output logic        redirect,
  output logic [31:0] redirect_pc,
  output priv_level_t curr_priv
);

  // CSR state seen by the trap controller
  logic         mstatus_mie;
  priv_level_t  mstatus_mpp;
  logic [11:0]  mie_bits;
  logic [11:0]  mip_bits;
  logic [29:0]  mtvec_base;
  vector_mode_t mtvec_mode;
  logic [31:0]  mepc;

  // Trap and return updates back into the CSR file
  logic         trap_enter;
  logic         trap_is_int;
  logic [3:0]   trap_cause;
  logic [31:0]  trap_epc;
  logic [31:0]  trap_tval;
  logic         mret_commit;

  // Port names match the wires above
  priv_csr_file u_csr_file (
    .*
  );

  priv_trap_control u_trap_control (
    .*
  );

endmodule

// ==== tb.f ====
+incdir+.
machine_csr_pkg.sv
trap_pkg.sv
priv_csr_file.sv
priv_trap_control.sv
priv_unit.sv
tb_priv_unit.sv

// ==== tb_priv_model.svh ====
// Shadow CSR state, CSR lookup, trap prediction and per-edge update for the testbench

logic [1:0]  sh_priv;
logic [31:0] sh_mstatus;  // Read value, only mie, mpie and mpp move
logic [11:0] sh_mie, sh_mip;
logic [31:0] sh_mtvec, sh_mscratch, sh_mepc, sh_mcause, sh_mtval;
logic [31:0] sh_mcounteren, sh_mcountinhibit;
logic [63:0] sh_mcycle, sh_minstret;

task automatic reset_shadow();
  sh_priv          = M_MODE;
  sh_mstatus       = 32'h0000_1800;  // mpp = M
  sh_mie           = '0;
  sh_mip           = '0;
  sh_mtvec         = '0;
  sh_mscratch      = '0;
  sh_mepc          = '0;
  sh_mcause        = '0;
  sh_mtval         = '0;
  sh_mcounteren    = '1;
  sh_mcountinhibit = '1;
  sh_mcycle        = '0;
  sh_minstret      = '0;
endtask

// Returns {exists, read value}
function automatic logic [32:0] lookup_csr(input logic [11:0] a);
  case (a)
    MVENDORID_ADDR, MARCHID_ADDR, MIMPID_ADDR, MCONFIGPTR_ADDR, MSTATUSH_ADDR: return {1'b1, 32'h0};
    MHARTID_ADDR:       return {1'b1, `PRIV_HARTID};
    MISA_ADDR:          return {1'b1, 32'h4000_0100 | ({31'b0, `PRIV_EXT_M} << 12) |
                                ({31'b0, `PRIV_EXT_U} << 20)};  // MXL 1, I, M, U
    MSTATUS_ADDR:       return {1'b1, sh_mstatus};
    MIE_ADDR:           return {1'b1, 20'b0, sh_mie};
    MTVEC_ADDR:         return {1'b1, sh_mtvec};
    MCOUNTEREN_ADDR:    return {1'b1, sh_mcounteren};
    MCOUNTINHIBIT_ADDR: return {1'b1, sh_mcountinhibit};
    MSCRATCH_ADDR:      return {1'b1, sh_mscratch};
    MEPC_ADDR:          return {1'b1, sh_mepc};
    MCAUSE_ADDR:        return {1'b1, sh_mcause};
    MTVAL_ADDR:         return {1'b1, sh_mtval};
    MIP_ADDR:           return {1'b1, 20'b0, sh_mip};
    MCYCLE_ADDR:        return {1'b1, sh_mcycle[31:0]};
    MINSTRET_ADDR:      return {1'b1, sh_minstret[31:0]};
    MCYCLEH_ADDR:       return {1'b1, sh_mcycle[63:32]};
    MINSTRETH_ADDR:     return {1'b1, sh_minstret[63:32]};
    default:            return {1'b0, 32'h0};
  endcase
endfunction

// Returns {take, code}, external before software before timer
function automatic logic [4:0] pick_interrupt();
  logic [11:0] pend;
  pend = sh_mie & sh_mip;
  if (!sh_mstatus[3] && sh_priv != U_MODE) begin
    return 5'd0;  // Globally masked in M mode
  end
  return pend[11] ? {1'b1, 4'd11} :
         pend[3]  ? {1'b1, 4'd3}  :
         pend[7]  ? {1'b1, 4'd7}  : 5'd0;
endfunction

function automatic logic [31:0] trap_target(input logic is_int, input logic [3:0] code);
  logic [31:0] base;
  base = {sh_mtvec[31:2], 2'b00};
  if (is_int && sh_mtvec[1:0] == 2'b01) begin
    base = base + {26'b0, code, 2'b00};  // Vectored interrupts only
  end
  return base;
endfunction

task automatic predict_outputs(output logic [31:0] rdata, output logic invalid,
                               output logic redir, output logic [31:0] pc);
  logic [11:0] a;
  logic [32:0] rd;
  logic [4:0]  irq;
  a       = csr_addr;
  rd      = lookup_csr(a);
  irq     = pick_interrupt();
  rdata   = rd[31:0];
  invalid = !rd[32] || (a[9:8] > sh_priv);
  redir   = exc_valid || irq[4] || (mret && sh_priv == M_MODE);
  if (exc_valid) begin
    pc = trap_target(1'b0, exc_cause);
  end else if (irq[4]) begin
    pc = trap_target(1'b1, irq[3:0]);
  end else begin
    pc = sh_mepc;  // mret
  end
endtask

// Moves the shadow state across one rising edge with the inputs now applied
task automatic advance_shadow();
  logic [11:0] a;
  logic [32:0] rd;
  logic [31:0] nv;
  logic [31:0] old_mstatus;
  logic [1:0]  old_priv;
  logic [4:0]  irq;
  logic        trap, ret, we, cy_run, ir_run;
  a           = csr_addr;
  rd          = lookup_csr(a);
  old_mstatus = sh_mstatus;
  old_priv    = sh_priv;
  irq         = pick_interrupt();
  trap        = exc_valid || irq[4];
  ret         = mret && sh_priv == M_MODE && !trap;
  we          = (csr_write || csr_set || csr_clear) && rd[32] && (a[9:8] <= sh_priv);
  cy_run      = !sh_mcountinhibit[0];  // Inhibit bits as seen at this edge
  ir_run      = !sh_mcountinhibit[2];
  nv          = csr_set   ? (rd[31:0] | csr_wdata) :
                csr_clear ? (rd[31:0] & ~csr_wdata) : csr_wdata;
  if (we) begin
    case (a)
      MSTATUS_ADDR:       sh_mstatus = {19'b0, {2{nv[12] & nv[11]}}, 3'b0, nv[7], 3'b0, nv[3], 3'b0};
      MIE_ADDR:           sh_mie = nv[11:0] & 12'h888;
      MTVEC_ADDR:         sh_mtvec = {nv[31:2], 1'b0, nv[1:0] == 2'b01};
      MIP_ADDR:           sh_mip[3] = nv[3];
      MCOUNTEREN_ADDR:    sh_mcounteren = nv;
      MCOUNTINHIBIT_ADDR: sh_mcountinhibit = nv;
      MSCRATCH_ADDR:      sh_mscratch = nv;
      MEPC_ADDR:          sh_mepc = nv;
      MCAUSE_ADDR:        sh_mcause = nv;
      MTVAL_ADDR:         sh_mtval = nv;
      default: ;
    endcase
  end
  if (we && a == MCYCLE_ADDR) begin
    sh_mcycle[31:0] = nv;
  end else if (cy_run) begin
    sh_mcycle = sh_mcycle + 64'd1;
  end
  if (we && a == MINSTRET_ADDR) begin
    sh_minstret[31:0] = nv;
  end else if (ir_run) begin
    sh_minstret = sh_minstret + {63'b0, inst_ret};
  end
  sh_mip[7]  = timer_irq;
  sh_mip[11] = ext_irq;
  if (trap) begin
    sh_mepc    = exc_epc;
    sh_mcause  = exc_valid ? {28'b0, exc_cause} : {1'b1, 27'b0, irq[3:0]};
    sh_mtval   = exc_valid ? exc_tval : 32'h0;
    sh_mstatus = {19'b0, old_priv, 3'b0, old_mstatus[3], 7'b0};  // mpie gets old mie
    sh_priv    = M_MODE;
  end else if (ret) begin
    sh_mstatus = {19'b0, 2'b00, 3'b0, 1'b1, 3'b0, old_mstatus[7], 3'b0};
    sh_priv    = old_mstatus[12:11];
  end
endtask

// ==== tb_priv_unit.sv ====
// Testbench top for the privilege unit with random stimulus checked against a shadow model
`include "priv_params.svh"

module tb_priv_unit import machine_csr_pkg::*, trap_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CYCLES   = 4000;
  localparam int READY_CYCLES = 20;

  localparam logic [11:0] ADDR_LIST [23] = '{
    12'hF11, 12'hF12, 12'hF13, 12'hF14, 12'hF15, 12'h300, 12'h301, 12'h304,
    12'h305, 12'h306, 12'h310, 12'h320, 12'h340, 12'h341, 12'h342, 12'h343,
    12'h344, 12'hB00, 12'hB02, 12'hB80, 12'hB82,
    12'h7C0, 12'hC00  // Not implemented
  };
  localparam logic [3:0] EXC_LIST [6] = '{4'd2, 4'd3, 4'd4, 4'd6, 4'd8, 4'd11};

  logic        CLK;
  logic        nRST;
  logic        csr_write, csr_set, csr_clear;
  csr_addr_t   csr_addr;
  logic [31:0] csr_wdata;
  logic        exc_valid;
  exc_cause_t  exc_cause;
  logic [31:0] exc_epc, exc_tval;
  logic        mret, inst_ret, ext_irq, timer_irq;
  logic [31:0] csr_rdata;
  logic        invalid_csr, redirect;
  logic [31:0] redirect_pc;
  priv_level_t curr_priv;

  integer      seed;
  int          checks, mismatches, failures;
  logic        ready;

  `include "tb_priv_model.svh"

  priv_unit u_dut (.*);

  always #5 CLK = ~CLK;

  task automatic wait_ready(output logic ok);
    int i;
    ok = 1'b0;
    for (i = 0; i < READY_CYCLES && !ok; i++) begin
      @(negedge CLK);
      ok = (curr_priv === M_MODE) && (redirect === 1'b0);
    end
    if (!ok) begin
      failures++;
      $display("Timeout: privilege unit not idle in M mode %0d cycles after reset", READY_CYCLES);
    end
  endtask

  task automatic drive_random();
    logic [31:0] rnd;
    int          idx;
    csr_write = 1'b0;
    csr_set   = 1'b0;
    csr_clear = 1'b0;
    exc_valid = 1'b0;
    mret      = 1'b0;
    rnd       = $random(seed);
    inst_ret  = rnd[3];
    if (rnd[4]) begin  // Otherwise read back the last address
      idx      = $unsigned($random(seed)) % 23;
      csr_addr = csr_addr_t'(ADDR_LIST[idx]);
    end
    case (rnd[6:5])  // Biased toward zero and a near-overflow counter value
      2'd0:    csr_wdata = 32'h0;
      2'd1:    csr_wdata = 32'hFFFF_FFF8;
      default: csr_wdata = $random(seed);
    endcase
    idx       = $unsigned($random(seed)) % 6;
    exc_cause = exc_cause_t'(EXC_LIST[idx]);
    exc_epc   = $random(seed);
    exc_tval  = $random(seed);
    case (rnd[2:0])
      3'd0, 3'd1, 3'd2: begin
        csr_write = (rnd[8:7] == 2'd0);
        csr_set   = (rnd[8:7] == 2'd1);
        csr_clear = rnd[8];
      end
      3'd3: exc_valid = 1'b1;
      3'd4: mret = 1'b1;
      3'd5: begin
        if (rnd[9]) begin
          ext_irq = !ext_irq;
        end else begin
          timer_irq = !timer_irq;
        end
      end
      default: ;
    endcase
  endtask

  task automatic check_outputs();
    logic [31:0] exp_rdata, exp_pc;
    logic        exp_invalid, exp_redirect;
    predict_outputs(exp_rdata, exp_invalid, exp_redirect, exp_pc);
    checks++;
    assert (csr_rdata === exp_rdata) else begin
      mismatches++;
      $display("MISMATCH at %0d ns: csr_rdata[%h] = %h, expected %h", $time, csr_addr,
               csr_rdata, exp_rdata);
    end
    assert (invalid_csr === exp_invalid) else begin
      mismatches++;
      $display("MISMATCH at %0d ns: invalid_csr[%h] = %b, expected %b", $time, csr_addr,
               invalid_csr, exp_invalid);
    end
    assert (redirect === exp_redirect) else begin
      mismatches++;
      $display("MISMATCH at %0d ns: redirect = %b, expected %b", $time, redirect, exp_redirect);
    end
    assert (!exp_redirect || redirect_pc === exp_pc) else begin
      mismatches++;
      $display("MISMATCH at %0d ns: redirect_pc = %h, expected %h", $time, redirect_pc, exp_pc);
    end
    assert (curr_priv === sh_priv) else begin
      mismatches++;
      $display("MISMATCH at %0d ns: curr_priv = %0d, expected %0d", $time, curr_priv, sh_priv);
    end
  endtask

  initial begin
    CLK        = 1'b0;
    nRST       = 1'b0;
    seed       = 32'he11081d0;
    checks     = 0;
    mismatches = 0;
    failures   = 0;
    csr_write  = 1'b0;
    csr_set    = 1'b0;
    csr_clear  = 1'b0;
    csr_addr   = MSTATUS_ADDR;
    csr_wdata  = 32'h0;
    exc_valid  = 1'b0;
    exc_cause  = EXC_ILLEGAL_INST;
    exc_epc    = 32'h0;
    exc_tval   = 32'h0;
    mret       = 1'b0;
    inst_ret   = 1'b0;
    ext_irq    = 1'b0;
    timer_irq  = 1'b0;
    reset_shadow();
    repeat (3) @(posedge CLK);
    #1 nRST = 1'b1;
    wait_ready(ready);
    if (ready) begin
      advance_shadow();  // Idle edge ahead of the first random cycle
      for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
        @(posedge CLK);
        #1;
        drive_random();
        #4;  // Outputs settled, next edge still ahead
        check_outputs();
        advance_shadow();
      end
    end
    $display("Report: %0d cycles checked, %0d mismatches, %0d other errors", checks,
             mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== trap_pkg.sv ====
// Exception and interrupt cause codes and interrupt bit positions
package trap_pkg;

  // Synchronous exception codes for mcause
  typedef enum logic [3:0] {
    EXC_ILLEGAL_INST     = 4'd2,
    EXC_BREAKPOINT       = 4'd3,
    EXC_LOAD_MISALIGNED  = 4'd4,
    EXC_STORE_MISALIGNED = 4'd6,
    EXC_ECALL_U          = 4'd8,
    EXC_ECALL_M          = 4'd11
  } exc_cause_t;

  // Machine interrupt codes, mcause bit 31 set
  typedef enum logic [3:0] {
    INT_M_SOFT  = 4'd3,
    INT_M_TIMER = 4'd7,
    INT_M_EXT   = 4'd11
  } int_cause_t;

  // Positions in mie and mip, equal to the interrupt codes
  localparam int MSIP_BIT = 3;
  localparam int MTIP_BIT = 7;
  localparam int MEIP_BIT = 11;

endpackage
